//--- Bender.yml
package:
  name: icb_2to1_bus

sources:
  - files:
      - hw/icb_bus_pkg.sv
      - hw/icb_arbt_ctrl.sv
      - hw/icb_cmd_buffer.sv
      - hw/icb_rsp_route.sv
      - hw/icb_2to1_bus.sv
  - target: simulation
    files:
      - verification/icb_clk_gen.sv
      - verification/tb_icb_2to1_bus.sv

# Testbench top: tb_icb_2to1_bus
# RTL top: icb_2to1_bus

//--- hw/icb_2to1_bus.sv
`timescale 1ns/10ps

module icb_2to1_bus (
  input  logic                       clk,
  input  logic                       i_arst_n,
  // Requester m0.
  input  logic                       i_m0_cmd_valid,
  output logic                       o_m0_cmd_ready,
  input  logic                       i_m0_cmd_read,
  input  logic [icb_bus_pkg::AW-1:0] i_m0_cmd_addr,
  input  logic [icb_bus_pkg::DW-1:0] i_m0_cmd_wdata,
  input  logic [icb_bus_pkg::MW-1:0] i_m0_cmd_wmask,
  input  logic                       i_m0_cmd_lock,
  output logic                       o_m0_rsp_valid,
  input  logic                       i_m0_rsp_ready,
  output logic                       o_m0_rsp_err,
  output logic [icb_bus_pkg::DW-1:0] o_m0_rsp_rdata,
  // Requester m1.
  input  logic                       i_m1_cmd_valid,
  output logic                       o_m1_cmd_ready,
  input  logic                       i_m1_cmd_read,
  input  logic [icb_bus_pkg::AW-1:0] i_m1_cmd_addr,
  input  logic [icb_bus_pkg::DW-1:0] i_m1_cmd_wdata,
  input  logic [icb_bus_pkg::MW-1:0] i_m1_cmd_wmask,
  input  logic                       i_m1_cmd_lock,
  output logic                       o_m1_rsp_valid,
  input  logic                       i_m1_rsp_ready,
  output logic                       o_m1_rsp_err,
  output logic [icb_bus_pkg::DW-1:0] o_m1_rsp_rdata,
  // Slave port.
  output logic                       o_icb_cmd_valid,
  input  logic                       i_icb_cmd_ready,
  output logic                       o_icb_cmd_read,
  output logic [icb_bus_pkg::AW-1:0] o_icb_cmd_addr,
  output logic [icb_bus_pkg::DW-1:0] o_icb_cmd_wdata,
  output logic [icb_bus_pkg::MW-1:0] o_icb_cmd_wmask,
  output logic                       o_icb_cmd_lock,
  input  logic                       i_icb_rsp_valid,
  output logic                       o_icb_rsp_ready,
  input  logic                       i_icb_rsp_err,
  input  logic [icb_bus_pkg::DW-1:0] i_icb_rsp_rdata,
  output logic                       o_active
);

  logic                              push;
  logic [icb_bus_pkg::MST_IDX_W-1:0] push_idx;
  logic                              buf_full;
  logic                              route_full;
  logic                              route_busy;

  icb_arbt_ctrl u_arbt_ctrl (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_m0_cmd_valid (i_m0_cmd_valid),
    .i_m0_cmd_lock  (i_m0_cmd_lock),
    .i_m1_cmd_valid (i_m1_cmd_valid),
    .i_m1_cmd_lock  (i_m1_cmd_lock),
    .i_buf_full     (buf_full),
    .i_buf_valid    (o_icb_cmd_valid),
    .i_route_full   (route_full),
    .i_route_busy   (route_busy),
    .o_m0_cmd_ready (o_m0_cmd_ready),
    .o_m1_cmd_ready (o_m1_cmd_ready),
    .o_push         (push),
    .o_push_idx     (push_idx),
    .o_active       (o_active)
  );

  icb_cmd_buffer u_cmd_buffer (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_push          (push),
    .i_push_idx      (push_idx),
    .i_m0_cmd_read   (i_m0_cmd_read),
    .i_m0_cmd_addr   (i_m0_cmd_addr),
    .i_m0_cmd_wdata  (i_m0_cmd_wdata),
    .i_m0_cmd_wmask  (i_m0_cmd_wmask),
    .i_m0_cmd_lock   (i_m0_cmd_lock),
    .i_m1_cmd_read   (i_m1_cmd_read),
    .i_m1_cmd_addr   (i_m1_cmd_addr),
    .i_m1_cmd_wdata  (i_m1_cmd_wdata),
    .i_m1_cmd_wmask  (i_m1_cmd_wmask),
    .i_m1_cmd_lock   (i_m1_cmd_lock),
    .i_icb_cmd_ready (i_icb_cmd_ready),
    .o_full          (buf_full),
    .o_icb_cmd_valid (o_icb_cmd_valid),
    .o_icb_cmd_read  (o_icb_cmd_read),
    .o_icb_cmd_addr  (o_icb_cmd_addr),
    .o_icb_cmd_wdata (o_icb_cmd_wdata),
    .o_icb_cmd_wmask (o_icb_cmd_wmask),
    .o_icb_cmd_lock  (o_icb_cmd_lock)
  );

  icb_rsp_route u_rsp_route (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_push          (push),
    .i_push_idx      (push_idx),
    .i_icb_rsp_valid (i_icb_rsp_valid),
    .i_icb_rsp_err   (i_icb_rsp_err),
    .i_icb_rsp_rdata (i_icb_rsp_rdata),
    .i_m0_rsp_ready  (i_m0_rsp_ready),
    .i_m1_rsp_ready  (i_m1_rsp_ready),
    .o_full          (route_full),
    .o_busy          (route_busy),
    .o_icb_rsp_ready (o_icb_rsp_ready),
    .o_m0_rsp_valid  (o_m0_rsp_valid),
    .o_m0_rsp_err    (o_m0_rsp_err),
    .o_m0_rsp_rdata  (o_m0_rsp_rdata),
    .o_m1_rsp_valid  (o_m1_rsp_valid),
    .o_m1_rsp_err    (o_m1_rsp_err),
    .o_m1_rsp_rdata  (o_m1_rsp_rdata)
  );

endmodule

//--- hw/icb_arbt_ctrl.sv
`timescale 1ns/10ps

module icb_arbt_ctrl (
  input  logic                               clk,
  input  logic                               i_arst_n,
  input  logic                               i_m0_cmd_valid,
  input  logic                               i_m0_cmd_lock,
  input  logic                               i_m1_cmd_valid,
  input  logic                               i_m1_cmd_lock,
  input  logic                               i_buf_full,
  input  logic                               i_buf_valid,
  input  logic                               i_route_full,
  input  logic                               i_route_busy,
  output logic                               o_m0_cmd_ready,
  output logic                               o_m1_cmd_ready,
  output logic                               o_push,
  output logic [icb_bus_pkg::MST_IDX_W-1:0]  o_push_idx,
  output logic                               o_active
);

  logic                              elig0;
  logic                              elig1;
  logic                              room;
  logic [icb_bus_pkg::MST_IDX_W-1:0] grant;
  logic [icb_bus_pkg::MST_IDX_W-1:0] last_grant;  // Winner of the last accept.
  logic [icb_bus_pkg::MST_IDX_W-1:0] lock_owner;
  logic                              lock_held;
  logic                              push_lock;

  // Downstream must have space in both the buffer and the routing queue.
  assign room  = ~i_buf_full & ~i_route_full;
  assign elig0 = i_m0_cmd_valid & room;
  assign elig1 = i_m1_cmd_valid & room;

  always_comb begin
    if (lock_held) begin
      grant = lock_owner;                  // Locked sequence keeps the port.
    end else if (elig0 & elig1) begin
      grant = ~last_grant;                 // Round robin on a tie.
    end else if (elig1) begin
      grant = 1'b1;
    end else begin
      grant = 1'b0;
    end
  end

  assign o_m0_cmd_ready = elig0 & (grant == 1'b0);
  assign o_m1_cmd_ready = elig1 & (grant == 1'b1);

  // A ready is only raised with valid, so either ready marks an accept.
  assign o_push     = o_m0_cmd_ready | o_m1_cmd_ready;
  assign o_push_idx = grant;
  assign push_lock  = grant[0] ? i_m1_cmd_lock : i_m0_cmd_lock;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      last_grant <= 1'b1;                  // First tie after reset goes to m0.
    end else if (o_push) begin
      last_grant <= grant;
    end
  end

  // Lock starts on a locked accept and ends on the owner's next unlocked accept.
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      lock_held  <= 1'b0;
      lock_owner <= 1'b0;
    end else if (o_push) begin
      lock_held <= push_lock;
      if (push_lock && !lock_held) begin
        lock_owner <= grant;
      end
    end
  end

  // Pending work anywhere on the bus.
  assign o_active = i_buf_valid | i_route_busy | lock_held;

endmodule

//--- hw/icb_bus_pkg.sv
package icb_bus_pkg;

  // Bus widths.
  localparam int AW = 32;
  localparam int DW = 32;
  localparam int MW = DW / 8;     // One mask bit per byte.

  // Requesters on the shared port.
  localparam int MST_NUM   = 2;
  localparam int MST_IDX_W = 1;

  // Command buffer toward the slave.
  localparam int CMD_FIFO_DP = 2;

  // Routing queue, which also bounds the commands in flight.
  localparam int OUTS_MAX   = 4;
  localparam int OUTS_CNT_W = 3;   // Holds 0 to OUTS_MAX.

endpackage

//--- hw/icb_cmd_buffer.sv
`timescale 1ns/10ps

module icb_cmd_buffer (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_push,
  input  logic [icb_bus_pkg::MST_IDX_W-1:0] i_push_idx,
  input  logic                              i_m0_cmd_read,
  input  logic [icb_bus_pkg::AW-1:0]        i_m0_cmd_addr,
  input  logic [icb_bus_pkg::DW-1:0]        i_m0_cmd_wdata,
  input  logic [icb_bus_pkg::MW-1:0]        i_m0_cmd_wmask,
  input  logic                              i_m0_cmd_lock,
  input  logic                              i_m1_cmd_read,
  input  logic [icb_bus_pkg::AW-1:0]        i_m1_cmd_addr,
  input  logic [icb_bus_pkg::DW-1:0]        i_m1_cmd_wdata,
  input  logic [icb_bus_pkg::MW-1:0]        i_m1_cmd_wmask,
  input  logic                              i_m1_cmd_lock,
  input  logic                              i_icb_cmd_ready,
  output logic                              o_full,
  output logic                              o_icb_cmd_valid,
  output logic                              o_icb_cmd_read,
  output logic [icb_bus_pkg::AW-1:0]        o_icb_cmd_addr,
  output logic [icb_bus_pkg::DW-1:0]        o_icb_cmd_wdata,
  output logic [icb_bus_pkg::MW-1:0]        o_icb_cmd_wmask,
  output logic                              o_icb_cmd_lock
);

  logic                       mem_read  [icb_bus_pkg::CMD_FIFO_DP];
  logic [icb_bus_pkg::AW-1:0] mem_addr  [icb_bus_pkg::CMD_FIFO_DP];
  logic [icb_bus_pkg::DW-1:0] mem_wdata [icb_bus_pkg::CMD_FIFO_DP];
  logic [icb_bus_pkg::MW-1:0] mem_wmask [icb_bus_pkg::CMD_FIFO_DP];
  logic                       mem_lock  [icb_bus_pkg::CMD_FIFO_DP];

  logic [$clog2(icb_bus_pkg::CMD_FIFO_DP)-1:0]   wptr;
  logic [$clog2(icb_bus_pkg::CMD_FIFO_DP)-1:0]   rptr;
  logic [$clog2(icb_bus_pkg::CMD_FIFO_DP+1)-1:0] count;
  logic                                          pop;

  assign pop = o_icb_cmd_valid & i_icb_cmd_ready;

  // Payload storage, written from the granted requester.
  always_ff @(posedge clk) begin
    if (i_push) begin
      mem_read[wptr]  <= i_push_idx[0] ? i_m1_cmd_read  : i_m0_cmd_read;
      mem_addr[wptr]  <= i_push_idx[0] ? i_m1_cmd_addr  : i_m0_cmd_addr;
      mem_wdata[wptr] <= i_push_idx[0] ? i_m1_cmd_wdata : i_m0_cmd_wdata;
      mem_wmask[wptr] <= i_push_idx[0] ? i_m1_cmd_wmask : i_m0_cmd_wmask;
      mem_lock[wptr]  <= i_push_idx[0] ? i_m1_cmd_lock  : i_m0_cmd_lock;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (i_push) begin
        wptr <= wptr + 1'b1;  // Depth is a power of two, so it wraps.
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_full          = (count == icb_bus_pkg::CMD_FIFO_DP);
  assign o_icb_cmd_valid = (count != '0);

  // Head entry is presented to the slave.
  assign o_icb_cmd_read  = mem_read[rptr];
  assign o_icb_cmd_addr  = mem_addr[rptr];
  assign o_icb_cmd_wdata = mem_wdata[rptr];
  assign o_icb_cmd_wmask = mem_wmask[rptr];
  assign o_icb_cmd_lock  = mem_lock[rptr];

endmodule

//--- hw/icb_rsp_route.sv
`timescale 1ns/10ps

module icb_rsp_route (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_push,
  input  logic [icb_bus_pkg::MST_IDX_W-1:0] i_push_idx,
  input  logic                              i_icb_rsp_valid,
  input  logic                              i_icb_rsp_err,
  input  logic [icb_bus_pkg::DW-1:0]        i_icb_rsp_rdata,
  input  logic                              i_m0_rsp_ready,
  input  logic                              i_m1_rsp_ready,
  output logic                              o_full,
  output logic                              o_busy,
  output logic                              o_icb_rsp_ready,
  output logic                              o_m0_rsp_valid,
  output logic                              o_m0_rsp_err,
  output logic [icb_bus_pkg::DW-1:0]        o_m0_rsp_rdata,
  output logic                              o_m1_rsp_valid,
  output logic                              o_m1_rsp_err,
  output logic [icb_bus_pkg::DW-1:0]        o_m1_rsp_rdata
);

  // Source index of every command still waiting for its response.
  logic [icb_bus_pkg::MST_IDX_W-1:0]          src_q [icb_bus_pkg::OUTS_MAX];
  logic [$clog2(icb_bus_pkg::OUTS_MAX)-1:0]   wptr;
  logic [$clog2(icb_bus_pkg::OUTS_MAX)-1:0]   rptr;
  logic [icb_bus_pkg::OUTS_CNT_W-1:0]         count;
  logic [icb_bus_pkg::MST_IDX_W-1:0]          head;
  logic                                       pop;

  always_ff @(posedge clk) begin
    if (i_push) begin
      src_q[wptr] <= i_push_idx;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (i_push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_full = (count == icb_bus_pkg::OUTS_MAX);
  assign o_busy = (count != '0);
  assign head   = src_q[rptr];

  // Response goes to the oldest issuer only.
  assign o_m0_rsp_valid  = i_icb_rsp_valid & o_busy & (head == 1'b0);
  assign o_m1_rsp_valid  = i_icb_rsp_valid & o_busy & (head == 1'b1);
  assign o_icb_rsp_ready = o_busy & (head[0] ? i_m1_rsp_ready : i_m0_rsp_ready);
  assign pop             = i_icb_rsp_valid & o_icb_rsp_ready;

  // Data fans out, valid decides who takes it.
  assign o_m0_rsp_err   = i_icb_rsp_err;
  assign o_m0_rsp_rdata = i_icb_rsp_rdata;
  assign o_m1_rsp_err   = i_icb_rsp_err;
  assign o_m1_rsp_rdata = i_icb_rsp_rdata;

endmodule

//--- verification/icb_clk_gen.sv
`timescale 1ns/10ps

module icb_clk_gen (
  output logic o_clk,
  output logic o_arst_n
);

  localparam int HALF_NS = 2;  // 4 ns period.

  initial begin
    o_clk = 1'b0;
    forever #HALF_NS o_clk = ~o_clk;
  end

  // Reset held for two rising edges, released just after the second.
  initial begin
    o_arst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #1 o_arst_n = 1'b1;
  end

endmodule

//--- verification/tb_icb_2to1_bus.sv
`timescale 1ns/10ps

module tb_icb_2to1_bus;

  localparam int NUM_ENT = 20;
  localparam int CLK_NS  = 4;

  logic clk;
  logic arst_n;
  logic [1:0] m_valid;
  logic [1:0] m_read;
  logic [1:0] m_lock;
  logic [1:0] m_rsp_ready;
  wire  [1:0] m_ready;
  wire  [1:0] m_rsp_valid;
  wire  [1:0] m_rsp_err;
  logic [icb_bus_pkg::AW-1:0] m_addr  [2];
  logic [icb_bus_pkg::DW-1:0] m_wdata [2];
  logic [icb_bus_pkg::MW-1:0] m_wmask [2];
  logic [icb_bus_pkg::DW-1:0] rdata0, rdata1;
  logic s_cmd_valid, s_cmd_ready, s_read, s_lock, s_rsp_valid, s_rsp_ready, s_rsp_err;
  logic [icb_bus_pkg::AW-1:0] s_addr;
  logic [icb_bus_pkg::DW-1:0] s_wdata, s_rsp_rdata;
  logic [icb_bus_pkg::MW-1:0] s_wmask;
  logic active;

  // Stimulus table.
  int t_req [NUM_ENT];
  int t_start [NUM_ENT];
  logic t_read [NUM_ENT];
  logic t_lock [NUM_ENT];
  logic [icb_bus_pkg::AW-1:0] t_addr [NUM_ENT];
  logic [icb_bus_pkg::DW-1:0] t_wdata [NUM_ENT];
  logic [icb_bus_pkg::MW-1:0] t_wmask [NUM_ENT];
  int n_ent = 0;

  // Reference state kept from observed handshakes.
  int cycle = 0;
  int cur [2];
  int buf_cnt = 0;
  int outs_cnt = 0;
  logic [1:0] acc_seen = 2'b00;
  logic last_gnt = 1'b1;  // First tie goes to m0.
  logic lock_on = 1'b0;
  logic lock_own = 1'b0;
  logic rsp_fired = 1'b0;
  logic [15:0] lfsr = 16'd20913;
  logic [69:0] cmd_q [$];
  logic [32:0] rsp_exp_q [$];
  int rsp_iss_q [$];
  logic [icb_bus_pkg::AW-1:0] slv_q [$];

  icb_clk_gen u_clk_gen (.o_clk(clk), .o_arst_n(arst_n));

  icb_2to1_bus dut0 (
    .clk (clk), .i_arst_n (arst_n),
    .i_m0_cmd_valid (m_valid[0]), .o_m0_cmd_ready (m_ready[0]), .i_m0_cmd_read (m_read[0]),
    .i_m0_cmd_addr (m_addr[0]), .i_m0_cmd_wdata (m_wdata[0]), .i_m0_cmd_wmask (m_wmask[0]),
    .i_m0_cmd_lock (m_lock[0]), .o_m0_rsp_valid (m_rsp_valid[0]),
    .i_m0_rsp_ready (m_rsp_ready[0]), .o_m0_rsp_err (m_rsp_err[0]), .o_m0_rsp_rdata (rdata0),
    .i_m1_cmd_valid (m_valid[1]), .o_m1_cmd_ready (m_ready[1]), .i_m1_cmd_read (m_read[1]),
    .i_m1_cmd_addr (m_addr[1]), .i_m1_cmd_wdata (m_wdata[1]), .i_m1_cmd_wmask (m_wmask[1]),
    .i_m1_cmd_lock (m_lock[1]), .o_m1_rsp_valid (m_rsp_valid[1]),
    .i_m1_rsp_ready (m_rsp_ready[1]), .o_m1_rsp_err (m_rsp_err[1]), .o_m1_rsp_rdata (rdata1),
    .o_icb_cmd_valid (s_cmd_valid), .i_icb_cmd_ready (s_cmd_ready), .o_icb_cmd_read (s_read),
    .o_icb_cmd_addr (s_addr), .o_icb_cmd_wdata (s_wdata), .o_icb_cmd_wmask (s_wmask),
    .o_icb_cmd_lock (s_lock), .i_icb_rsp_valid (s_rsp_valid), .o_icb_rsp_ready (s_rsp_ready),
    .i_icb_rsp_err (s_rsp_err), .i_icb_rsp_rdata (s_rsp_rdata), .o_active (active)
  );

  task automatic check_equal(input string name, input logic [71:0] exp, input logic [71:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch in %s.", name);
    end
  endtask

  task automatic add_entry(input int req, input logic rd, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] wmask,
                           input logic lock, input int start);
    t_req[n_ent]   = req;
    t_read[n_ent]  = rd;
    t_addr[n_ent]  = addr;
    t_wdata[n_ent] = wdata;
    t_wmask[n_ent] = wmask;
    t_lock[n_ent]  = lock;
    t_start[n_ent] = start;
    n_ent = n_ent + 1;
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] draw_bits(input int n);
    logic [7:0] v;
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // One step per bit.
    end
    return v;
  endfunction

  // Walks the table and presents this requester's entries in order.
  task automatic drive_requester(input int r);
    int i;
    for (i = 0; i < n_ent; i++) begin
      if (t_req[i] == r) begin
        while (cycle < t_start[i]) begin
          m_valid[r] = 1'b0;
          @(posedge clk);
          #1;
        end
        cur[r]     = i;
        m_read[r]  = t_read[i];
        m_addr[r]  = t_addr[i];
        m_wdata[r] = t_wdata[i];
        m_wmask[r] = t_wmask[i];
        m_lock[r]  = t_lock[i];
        m_valid[r] = 1'b1;
        do begin
          @(posedge clk);
          #1;
        end while (!acc_seen[r]);
        acc_seen[r] = 1'b0;
        m_valid[r]  = 1'b0;
      end
    end
  endtask

  always @(posedge clk) begin : monitor
    logic [1:0] elig;
    logic [1:0] exp_rdy;
    logic       room;
    int         r;
    int         head;
    if (arst_n) begin
      cycle = cycle + 1;
      room = (buf_cnt < icb_bus_pkg::CMD_FIFO_DP) && (outs_cnt < icb_bus_pkg::OUTS_MAX);
      elig = m_valid & {2{room}};
      exp_rdy = 2'b00;
      if (lock_on) begin
        exp_rdy[lock_own] = elig[lock_own];  // Lock owner keeps the port.
      end else if (elig == 2'b11) begin
        exp_rdy[~last_gnt] = 1'b1;
      end else begin
        exp_rdy = elig;
      end
      check_equal("cmd ready", exp_rdy, m_ready);
      check_equal("slave cmd valid", buf_cnt != 0, s_cmd_valid);
      check_equal("active", (buf_cnt != 0) || (outs_cnt != 0) || lock_on, active);
      for (r = 0; r < 2; r++) begin
        if (m_valid[r] && m_ready[r]) begin
          cmd_q.push_back({t_read[cur[r]], t_addr[cur[r]], t_wdata[cur[r]],
                           t_wmask[cur[r]], t_lock[cur[r]]});
          rsp_exp_q.push_back({t_addr[cur[r]][31], t_addr[cur[r]] ^ 32'h5A5A_0000});
          rsp_iss_q.push_back(r);
          acc_seen[r] = 1'b1;
          last_gnt = r[0];
          lock_on = t_lock[cur[r]];
          lock_own = r[0];
          buf_cnt = buf_cnt + 1;
          outs_cnt = outs_cnt + 1;
        end
      end
      if (s_cmd_valid && s_cmd_ready) begin
        check_equal("slave cmd fields", cmd_q.pop_front(),
                    {s_read, s_addr, s_wdata, s_wmask, s_lock});
        slv_q.push_back(s_addr);
        buf_cnt = buf_cnt - 1;
      end
      if (s_rsp_valid) begin
        head = rsp_iss_q[0];
        check_equal("rsp valid routing", (head == 0) ? 2'b01 : 2'b10, m_rsp_valid);
        check_equal("slave rsp ready", m_rsp_ready[head], s_rsp_ready);
        check_equal("rsp data", rsp_exp_q[0],
                    {m_rsp_err[head], (head == 0) ? rdata0 : rdata1});
        if (m_rsp_ready[head]) begin
          void'(rsp_exp_q.pop_front());
          void'(rsp_iss_q.pop_front());
          void'(slv_q.pop_front());
          outs_cnt = outs_cnt - 1;
          rsp_fired = 1'b1;
        end
      end else begin
        check_equal("rsp valid idle", 2'b00, m_rsp_valid);
      end
      check_equal("outstanding bound", 1'b1, slv_q.size() <= icb_bus_pkg::OUTS_MAX);
    end
  end

  // Slave answers in order after a random delay.
  initial begin : slave_model
    int         delay_left;
    logic       delay_set;
    logic [7:0] pick;
    delay_left = 0;
    delay_set  = 1'b0;
    wait (arst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      pick        = draw_bits(1);
      s_cmd_ready = pick[0];
      pick        = draw_bits(2);
      m_rsp_ready = pick[1:0];  // Requesters take responses at random too.
      if (rsp_fired) begin
        s_rsp_valid = 1'b0;
        delay_set   = 1'b0;
        rsp_fired   = 1'b0;
      end
      if (!s_rsp_valid && slv_q.size() != 0) begin
        if (!delay_set) begin
          delay_left = draw_bits(4);
          delay_set  = 1'b1;
        end
        if (delay_left == 0) begin
          s_rsp_valid = 1'b1;
          s_rsp_rdata = slv_q[0] ^ 32'h5A5A_0000;
          s_rsp_err   = slv_q[0][31];
        end else begin
          delay_left = delay_left - 1;
        end
      end
    end
  end

  initial begin : watchdog
    #(NUM_ENT * 200 * CLK_NS);
    $display("Watchdog expired: the run did not finish in %0d cycles.", NUM_ENT * 200);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Timeout.");
  end

  initial begin
    m_valid = 2'b00;
    m_read = 2'b00;
    m_lock = 2'b00;
    m_rsp_ready = 2'b11;
    for (int k = 0; k < 2; k++) begin
      m_addr[k]  = '0;
      m_wdata[k] = '0;
      m_wmask[k] = '0;
      cur[k]     = 0;
    end
    s_cmd_ready = 1'b0;
    s_rsp_valid = 1'b0;
    s_rsp_err = 1'b0;
    s_rsp_rdata = '0;
    add_entry(0, 1'b0, 32'h0000_0100, 32'h1111_0001, 4'hF, 1'b0, 2);
    add_entry(0, 1'b1, 32'h0000_0104, 32'h0, 4'h0, 1'b0, 2);
    add_entry(0, 1'b1, 32'h8000_0108, 32'h0, 4'h0, 1'b0, 2);
    add_entry(1, 1'b0, 32'h0000_0200, 32'h2222_0002, 4'h3, 1'b0, 40);
    add_entry(1, 1'b1, 32'h0000_0204, 32'h0, 4'h0, 1'b0, 40);
    add_entry(1, 1'b0, 32'h8000_0208, 32'h2222_0003, 4'hC, 1'b0, 40);
    add_entry(0, 1'b1, 32'h0000_0300, 32'h0, 4'h0, 1'b0, 80);  // Both requesters at once.
    add_entry(1, 1'b1, 32'h0000_0400, 32'h0, 4'h0, 1'b0, 80);
    add_entry(0, 1'b0, 32'h0000_0304, 32'h3333_0004, 4'h1, 1'b0, 80);
    add_entry(1, 1'b0, 32'h8000_0404, 32'h4444_0005, 4'h8, 1'b0, 80);
    add_entry(0, 1'b0, 32'h0000_0500, 32'h5555_0006, 4'hF, 1'b1, 130);  // Locked run.
    add_entry(0, 1'b0, 32'h0000_0504, 32'h5555_0007, 4'hF, 1'b1, 130);
    add_entry(0, 1'b1, 32'h0000_0508, 32'h0, 4'h0, 1'b1, 130);
    add_entry(0, 1'b1, 32'h0000_050C, 32'h0, 4'h0, 1'b0, 130);
    add_entry(1, 1'b1, 32'h0000_0600, 32'h0, 4'h0, 1'b0, 130);
    add_entry(1, 1'b0, 32'h0000_0604, 32'h6666_0008, 4'h6, 1'b0, 130);
    add_entry(0, 1'b1, 32'h0000_0700, 32'h0, 4'h0, 1'b0, 180);
    add_entry(1, 1'b1, 32'h0000_0800, 32'h0, 4'h0, 1'b0, 180);
    add_entry(0, 1'b0, 32'h8000_0704, 32'h7777_0009, 4'hA, 1'b0, 180);
    add_entry(1, 1'b0, 32'h0000_0804, 32'h8888_000A, 4'h5, 1'b0, 180);
    wait (arst_n === 1'b1);
    @(posedge clk);
    check_equal("idle after reset", 6'b0, {s_cmd_valid, m_rsp_valid, m_ready, active});
    #1;
    fork
      drive_requester(0);
      drive_requester(1);
    join
    while (rsp_exp_q.size() != 0 || cmd_q.size() != 0) @(posedge clk);
    @(posedge clk);
    check_equal("drain active", 1'b0, active);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- vlog.f
hw/icb_bus_pkg.sv
hw/icb_arbt_ctrl.sv
hw/icb_cmd_buffer.sv
hw/icb_rsp_route.sv
hw/icb_2to1_bus.sv
verification/icb_clk_gen.sv
verification/tb_icb_2to1_bus.sv
